// ==== vlog.f ====
+incdir+src
src/rp_pkg.sv
src/adc_frontend.sv
src/dac_backend.sv
src/lock_monitor.sv
src/trigger_router.sv
src/rp_analog_top.sv
tb/tb_checker.sv
tb/tb_top.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_top
FLIST     ?= vlog.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing -Wno-fatal
PASS_MSG  ?= ALL CHECKS PASSED

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FLIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx '$(PASS_MSG)'

clean:
	rm -rf $(OBJ_DIR)

// ==== tb/tb_top.sv ====
//////////////////////////////
// Testbench top for the analog path
// Clock, reset, seeded random stimulus
// DUT and checker instances, end of run
//////////////////////////////

`include "rp_macros.svh"

module tb_top;

  localparam int SMP_MAX = (1 << (`RP_SMP_W-1)) - 1;  // Most positive sample

  logic                adc_clk;
  logic                arst_n_i;
  // ADC and loopback
  rp_pkg::adc_raw_t    adc_a_i, adc_b_i;
  logic                digital_loop_i;
  rp_pkg::sample_t     adc_dat_a_o, adc_dat_b_o;
  // DAC sources and codes
  rp_pkg::sample_t     gen_a_i, gen_b_i, ctl_a_i, ctl_b_i;
  rp_pkg::dac_code_t   dac_a_o, dac_b_o;
  // Lock status
  logic                pll_locked_i;
  rp_pkg::diag_cnt_t   unlock_cnt_o;
  // Triggers and expansion N
  rp_pkg::par_word_t   par_dat_i;
  rp_pkg::daisy_mode_t daisy_mode_i;
  logic                gpio_trig_i, scope_trig_i, gen_trig_i;
  logic                trig_ext_o, trig_out_o;
  rp_pkg::exp_vec_t    exp_n_hk_dat_i, exp_n_hk_dir_i;
  rp_pkg::exp_vec_t    exp_n_dat_o, exp_n_dir_o;

  int                  timeout_cnt;  // Waits that ran out
  int                  err_total;    // Summed up by the checker
  logic                finish_req;   // Checker prints its counts on the rise

  always #10 adc_clk = ~adc_clk;     // Period 20

  rp_analog_top rp_analog_top_inst (.*);

  tb_checker tb_checker_inst (
    .*,
    .timeout_cnt_i (timeout_cnt),
    .finish_req_i  (finish_req),
    .err_total_o   (err_total)
  );

  //////////////////////////////
  // Stimulus helpers
  //////////////////////////////

  // Drive point, shortly after the rising edge
  task automatic next_cycle();
    @(posedge adc_clk);
    #2;
  endtask

  // Within 64 codes of either end of the range
  function automatic rp_pkg::sample_t near_rail();
    int v;
    v = $urandom_range(0, 63);
    v = $urandom_range(0, 1) ? SMP_MAX - v : v - SMP_MAX - 1;
    return v[`RP_SMP_W-1:0];
  endfunction

  // New values on every data and trigger input
  task automatic drive_random(input logic loop_on, input logic rails);
    adc_a_i        = rp_pkg::adc_raw_t'($urandom);
    adc_b_i        = rp_pkg::adc_raw_t'($urandom);
    digital_loop_i = loop_on;
    gen_a_i        = rails ? near_rail() : rp_pkg::sample_t'($urandom);
    gen_b_i        = rails ? near_rail() : rp_pkg::sample_t'($urandom);
    ctl_a_i        = rails ? near_rail() : rp_pkg::sample_t'($urandom);
    ctl_b_i        = rails ? near_rail() : rp_pkg::sample_t'($urandom);
    par_dat_i      = $urandom_range(0, 1) ? '0 : rp_pkg::par_word_t'($urandom);  // Idle half
    daisy_mode_i   = rp_pkg::daisy_mode_t'($urandom);
    gpio_trig_i    = 1'($urandom);
    scope_trig_i   = 1'($urandom);
    gen_trig_i     = 1'($urandom);
    exp_n_hk_dat_i = rp_pkg::exp_vec_t'($urandom);
    exp_n_hk_dir_i = rp_pkg::exp_vec_t'($urandom);
  endtask

  //////////////////////////////
  // Main sequence
  //////////////////////////////

  initial begin : stim
    int                total_low;   // Lock pin low cycles driven
    int                pulse_len;
    int                gap_len;
    int                waited;
    rp_pkg::diag_cnt_t exp_cnt;
    void'($urandom(29));
    adc_clk      = 1'b0;
    arst_n_i     = 1'b0;
    pll_locked_i = 1'b1;
    timeout_cnt  = 0;
    finish_req   = 1'b0;
    total_low    = 0;
    drive_random(1'b0, 1'b0);
    repeat (16) @(posedge adc_clk);  // Reset for 16 cycles
    #2;
    arst_n_i = 1'b1;

    // Direct ADC path, DAC sums pushed to the rails later on
    for (int i = 0; i < 600; i++) begin
      next_cycle();
      drive_random(1'b0, i >= 400);
    end

    // Loopback, rails every other cycle
    for (int i = 0; i < 300; i++) begin
      next_cycle();
      drive_random(1'b1, i[0]);
    end

    // Low pulses on the lock pin, high gaps between
    for (int p = 0; p < 10; p++) begin
      pulse_len = $urandom_range(1, 12);
      gap_len   = $urandom_range(1, 10);
      total_low += pulse_len;
      for (int i = 0; i < pulse_len + gap_len; i++) begin
        next_cycle();
        drive_random(1'b0, 1'b0);
        pll_locked_i = (i >= pulse_len);
      end
    end

    // Synchronizer leaves reset reading unlocked, adds its depth
    exp_cnt = rp_pkg::diag_cnt_t'(total_low + `RP_SYNC_STAGES);
    waited  = 0;
    while (unlock_cnt_o != exp_cnt && waited < 40) begin
      next_cycle();
      waited++;
    end
    if (unlock_cnt_o != exp_cnt) begin
      $display("Timeout: unlock counter stuck at %0d, never reached %0d", unlock_cnt_o, exp_cnt);
      timeout_cnt++;
    end
    repeat (5) next_cycle();  // Count must hold

    finish_req = 1'b1;
    #1;
    if (err_total == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

// ==== tb/tb_checker.sv ====
//////////////////////////////
// Checker for the analog path
// Reference models, per cycle compare
// Error counts and summary line
//////////////////////////////

`include "rp_macros.svh"

module tb_checker (
  input  logic                adc_clk,
  input  logic                arst_n_i,
  input  rp_pkg::adc_raw_t    adc_a_i,
  input  rp_pkg::adc_raw_t    adc_b_i,
  input  logic                digital_loop_i,
  input  rp_pkg::sample_t     adc_dat_a_o,
  input  rp_pkg::sample_t     adc_dat_b_o,
  input  rp_pkg::sample_t     gen_a_i,
  input  rp_pkg::sample_t     gen_b_i,
  input  rp_pkg::sample_t     ctl_a_i,
  input  rp_pkg::sample_t     ctl_b_i,
  input  rp_pkg::dac_code_t   dac_a_o,
  input  rp_pkg::dac_code_t   dac_b_o,
  input  logic                pll_locked_i,
  input  rp_pkg::diag_cnt_t   unlock_cnt_o,
  input  rp_pkg::par_word_t   par_dat_i,
  input  rp_pkg::daisy_mode_t daisy_mode_i,
  input  logic                gpio_trig_i,
  input  logic                scope_trig_i,
  input  logic                gen_trig_i,
  input  logic                trig_ext_o,
  input  logic                trig_out_o,
  input  rp_pkg::exp_vec_t    exp_n_hk_dat_i,
  input  rp_pkg::exp_vec_t    exp_n_hk_dir_i,
  input  rp_pkg::exp_vec_t    exp_n_dat_o,
  input  rp_pkg::exp_vec_t    exp_n_dir_o,
  input  int                  timeout_cnt_i,  // Counted by the top
  input  logic                finish_req_i,
  output int                  err_total_o
);

  localparam int SMP_MAX = (1 << (`RP_SMP_W-1)) - 1;  // +8191
  localparam int SMP_MIN = -(1 << (`RP_SMP_W-1));     // -8192
  localparam int TRIM    = `RP_ADC_IN_W - `RP_SMP_W;  // Raw LSBs dropped
  localparam int TW      = 2 * `RP_EXP_W + 2;         // Packed trigger result

  int                adc_errs  = 0;
  int                dac_errs  = 0;
  int                trig_errs = 0;
  int                lock_errs = 0;

  // Expected values at the next falling edge
  logic              have_pred = 1'b0;
  rp_pkg::sample_t   pred_adc_a;
  rp_pkg::sample_t   pred_adc_b;
  rp_pkg::dac_code_t pred_dac_a;
  rp_pkg::dac_code_t pred_dac_b;
  logic [TW-1:0]     pred_trig;
  rp_pkg::diag_cnt_t pred_cnt;
  logic [1:0]        low_hist;  // Lock pin low at the last two edges

  //////////////////////////////
  // Reference models
  //////////////////////////////

  // Sample is full scale minus the negative slope code
  function automatic rp_pkg::sample_t adc_ref(input rp_pkg::adc_raw_t raw);
    int v;
    v = SMP_MAX - (int'(raw) >> TRIM);
    return v[`RP_SMP_W-1:0];
  endfunction

  function automatic rp_pkg::sample_t sat_ref(
    input rp_pkg::sample_t g,
    input rp_pkg::sample_t c);
    int s;
    s = int'(g) + int'(c);
    s = (s > SMP_MAX) ? SMP_MAX : (s < SMP_MIN) ? SMP_MIN : s;  // Clamp to range
    return s[`RP_SMP_W-1:0];
  endfunction

  // Offset code counts down from the top
  function automatic rp_pkg::dac_code_t code_ref(input rp_pkg::sample_t smp);
    int v;
    v = SMP_MAX - int'(smp);
    return v[`RP_SMP_W-1:0];
  endfunction

  // Result packed as ext, out, N data, N direction
  function automatic logic [TW-1:0] trig_ref(
    input rp_pkg::par_word_t   par,
    input rp_pkg::daisy_mode_t mode,
    input logic                gpio,
    input logic                scope,
    input logic                gen,
    input rp_pkg::exp_vec_t    hk_dat,
    input rp_pkg::exp_vec_t    hk_dir);
    logic             ext;
    logic             out;
    rp_pkg::exp_vec_t dat;
    rp_pkg::exp_vec_t dir;
    ext = gpio && !(mode[0] && par != '0);  // Daisy trigger masks the pin in sync mode
    out = mode[2] ? gen : scope;
    dat = hk_dat;
    dir = hk_dir;
    if (mode[1]) begin
      dat[0] = dat[0] | out;  // Trigger onto N0
      dir[0] = 1'b1;
    end
    return {ext, out, dat, dir};
  endfunction

  function automatic int differs(
    input string       sig,
    input logic [31:0] exp_v,
    input logic [31:0] act_v);
    if (exp_v !== act_v) begin
      $display("FAIL t=%0t %s expected %0h actual %0h", $time, sig, exp_v, act_v);
      return 1;
    end
    return 0;
  endfunction

  //////////////////////////////
  // Compare on the falling edge
  //////////////////////////////

  always @(negedge adc_clk) begin
    if (!arst_n_i) begin
      adc_errs  += differs("adc_dat_a_o", '0, adc_dat_a_o);
      adc_errs  += differs("adc_dat_b_o", '0, adc_dat_b_o);
      dac_errs  += differs("dac_a_o", code_ref('0), dac_a_o);
      dac_errs  += differs("dac_b_o", code_ref('0), dac_b_o);
      trig_errs += differs("trig_ext_o", '0, trig_ext_o);
      trig_errs += differs("trig_out_o", '0, trig_out_o);
      trig_errs += differs("exp_n_dat_o", '0, exp_n_dat_o);
      trig_errs += differs("exp_n_dir_o", '0, exp_n_dir_o);
      lock_errs += differs("unlock_cnt_o", '0, unlock_cnt_o);
      have_pred = 1'b0;
      pred_cnt  = '0;
      low_hist  = 2'b11;  // Synchronizer comes out of reset unlocked
    end else begin
      if (have_pred) begin
        adc_errs  += differs("adc_dat_a_o", pred_adc_a, adc_dat_a_o);
        adc_errs  += differs("adc_dat_b_o", pred_adc_b, adc_dat_b_o);
        dac_errs  += differs("dac_a_o", pred_dac_a, dac_a_o);
        dac_errs  += differs("dac_b_o", pred_dac_b, dac_b_o);
        trig_errs += differs("trig_ext_o", pred_trig[TW-1], trig_ext_o);
        trig_errs += differs("trig_out_o", pred_trig[TW-2], trig_out_o);
        trig_errs += differs("exp_n_dat_o", pred_trig[TW-3 -: `RP_EXP_W], exp_n_dat_o);
        trig_errs += differs("exp_n_dir_o", pred_trig[`RP_EXP_W-1:0], exp_n_dir_o);
      end
      lock_errs += differs("unlock_cnt_o", pred_cnt, unlock_cnt_o);

      // Inputs seen now land on the next rising edge
      pred_adc_a = digital_loop_i ? sat_ref(gen_a_i, ctl_a_i) : adc_ref(adc_a_i);
      pred_adc_b = digital_loop_i ? sat_ref(gen_b_i, ctl_b_i) : adc_ref(adc_b_i);
      pred_dac_a = code_ref(sat_ref(gen_a_i, ctl_a_i));
      pred_dac_b = code_ref(sat_ref(gen_b_i, ctl_b_i));
      pred_trig  = trig_ref(par_dat_i, daisy_mode_i, gpio_trig_i, scope_trig_i, gen_trig_i,
                            exp_n_hk_dat_i, exp_n_hk_dir_i);
      pred_cnt   = pred_cnt + low_hist[1];  // Pin counts three edges after it changes
      low_hist   = {low_hist[0], ~pll_locked_i};
      have_pred  = 1'b1;
    end
  end

  assign err_total_o = adc_errs + dac_errs + trig_errs + lock_errs + timeout_cnt_i;

  always @(posedge finish_req_i) begin
    $display("Errors: adc %0d, dac %0d, trigger %0d, lock %0d, timeout %0d, total %0d",
             adc_errs, dac_errs, trig_errs, lock_errs, timeout_cnt_i, err_total_o);
  end

endmodule

// ==== src/rp_analog_top.sv ====
//////////////////////////////
// Analog path and glue top level
// ADC front end, DAC back end, lock monitor, triggers
//////////////////////////////

module rp_analog_top (
  input  logic                adc_clk,
  input  logic                arst_n_i,
  // ADC
  input  rp_pkg::adc_raw_t    adc_a_i,
  input  rp_pkg::adc_raw_t    adc_b_i,
  input  logic                digital_loop_i,
  output rp_pkg::sample_t     adc_dat_a_o,
  output rp_pkg::sample_t     adc_dat_b_o,
  // DAC sources and codes
  input  rp_pkg::sample_t     gen_a_i,
  input  rp_pkg::sample_t     gen_b_i,
  input  rp_pkg::sample_t     ctl_a_i,
  input  rp_pkg::sample_t     ctl_b_i,
  output rp_pkg::dac_code_t   dac_a_o,
  output rp_pkg::dac_code_t   dac_b_o,
  // Clock status
  input  logic                pll_locked_i,
  output rp_pkg::diag_cnt_t   unlock_cnt_o,
  // Triggers and daisy
  input  rp_pkg::par_word_t   par_dat_i,
  input  rp_pkg::daisy_mode_t daisy_mode_i,
  input  logic                gpio_trig_i,
  input  logic                scope_trig_i,
  input  logic                gen_trig_i,
  output logic                trig_ext_o,
  output logic                trig_out_o,
  // Expansion N
  input  rp_pkg::exp_vec_t    exp_n_hk_dat_i,
  input  rp_pkg::exp_vec_t    exp_n_hk_dir_i,
  output rp_pkg::exp_vec_t    exp_n_dat_o,
  output rp_pkg::exp_vec_t    exp_n_dir_o
);

  rp_pkg::sample_t loop_a;  // DAC to ADC loopback
  rp_pkg::sample_t loop_b;

  //////////////////////////////
  // Data path
  //////////////////////////////

  adc_frontend adc_frontend_inst (
    .adc_clk        (adc_clk),
    .arst_n_i       (arst_n_i),
    .adc_a_i        (adc_a_i),
    .adc_b_i        (adc_b_i),
    .digital_loop_i (digital_loop_i),
    .loop_a_i       (loop_a),
    .loop_b_i       (loop_b),
    .adc_dat_a_o    (adc_dat_a_o),
    .adc_dat_b_o    (adc_dat_b_o)
  );

  dac_backend dac_backend_inst (
    .adc_clk  (adc_clk),
    .arst_n_i (arst_n_i),
    .gen_a_i  (gen_a_i),
    .gen_b_i  (gen_b_i),
    .ctl_a_i  (ctl_a_i),
    .ctl_b_i  (ctl_b_i),
    .loop_a_o (loop_a),   // Combinational into the ADC mux
    .loop_b_o (loop_b),
    .dac_a_o  (dac_a_o),
    .dac_b_o  (dac_b_o)
  );

  //////////////////////////////
  // Glue
  //////////////////////////////

  lock_monitor lock_monitor_inst (
    .adc_clk      (adc_clk),
    .arst_n_i     (arst_n_i),
    .pll_locked_i (pll_locked_i),
    .unlock_cnt_o (unlock_cnt_o)
  );

  trigger_router trigger_router_inst (
    .adc_clk        (adc_clk),
    .arst_n_i       (arst_n_i),
    .par_dat_i      (par_dat_i),
    .daisy_mode_i   (daisy_mode_i),
    .gpio_trig_i    (gpio_trig_i),
    .scope_trig_i   (scope_trig_i),
    .gen_trig_i     (gen_trig_i),
    .exp_n_hk_dat_i (exp_n_hk_dat_i),
    .exp_n_hk_dir_i (exp_n_hk_dir_i),
    .trig_ext_o     (trig_ext_o),
    .trig_out_o     (trig_out_o),
    .exp_n_dat_o    (exp_n_dat_o),
    .exp_n_dir_o    (exp_n_dir_o)
  );

endmodule

// ==== src/trigger_router.sv ====
//////////////////////////////
// Trigger routing and expansion N overlay
// Daisy trigger, external gating, output select
//////////////////////////////

`include "rp_macros.svh"

module trigger_router (
  input  logic                adc_clk,
  input  logic                arst_n_i,
  // Daisy chain
  input  rp_pkg::par_word_t   par_dat_i,      // Receive word
  input  rp_pkg::daisy_mode_t daisy_mode_i,
  // Trigger sources
  input  logic                gpio_trig_i,    // External trigger pin
  input  logic                scope_trig_i,
  input  logic                gen_trig_i,
  // Housekeeping view of expansion N
  input  rp_pkg::exp_vec_t    exp_n_hk_dat_i,
  input  rp_pkg::exp_vec_t    exp_n_hk_dir_i,  // 1 drives the pin
  // Registered results
  output logic                trig_ext_o,
  output logic                trig_out_o,
  output rp_pkg::exp_vec_t    exp_n_dat_o,
  output rp_pkg::exp_vec_t    exp_n_dir_o
);

  logic             daisy_trig;   // Any bit set in the daisy word
  logic             sync_mode;
  logic             trig_out_en;  // Put the trigger on N0
  logic             trig_sel;     // Trigger sent out

  logic             trig_ext_d;
  rp_pkg::exp_vec_t dat_d;
  rp_pkg::exp_vec_t dir_d;

  assign sync_mode   = daisy_mode_i[0];
  assign trig_out_en = daisy_mode_i[1];

  //////////////////////////////
  // Trigger logic
  //////////////////////////////

  assign daisy_trig = |par_dat_i;

  // In sync mode an incoming daisy trigger masks the pin
  assign trig_ext_d = gpio_trig_i & ~(sync_mode & daisy_trig);

  assign trig_sel = daisy_mode_i[2] ? gen_trig_i : scope_trig_i;

  // Only pin 0 is taken over, the rest stay with housekeeping
  assign dat_d = exp_n_hk_dat_i | {{(`RP_EXP_W-1){1'b0}}, trig_out_en & trig_sel};
  assign dir_d = exp_n_hk_dir_i | {{(`RP_EXP_W-1){1'b0}}, trig_out_en};

  //////////////////////////////
  // Output register
  //////////////////////////////

  always_ff @(posedge adc_clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      trig_ext_o  <= 1'b0;
      trig_out_o  <= 1'b0;
      exp_n_dat_o <= '0;
      exp_n_dir_o <= '0;  // All pins inputs
    end else begin
      trig_ext_o  <= trig_ext_d;
      trig_out_o  <= trig_sel;
      exp_n_dat_o <= dat_d;
      exp_n_dir_o <= dir_d;
    end
  end

endmodule

// ==== src/lock_monitor.sv ====
//////////////////////////////
// PLL lock status monitor
// Synchronizer and unlocked cycle counter
//////////////////////////////

`include "rp_macros.svh"

module lock_monitor (
  input  logic              adc_clk,
  input  logic              arst_n_i,
  input  logic              pll_locked_i,  // Async, from the clock source
  output rp_pkg::diag_cnt_t unlock_cnt_o   // Read by housekeeping
);

  logic [`RP_SYNC_STAGES-1:0] sync_q;      // Stage 0 takes the raw pin
  logic                       locked_s;    // Lock status in adc_clk

  //////////////////////////////
  // Synchronizer
  //////////////////////////////

  always_ff @(posedge adc_clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      sync_q <= '0;  // Reads as not locked until the pin propagates
    end else begin
      sync_q <= {sync_q[`RP_SYNC_STAGES-2:0], pll_locked_i};
    end
  end

  assign locked_s = sync_q[`RP_SYNC_STAGES-1];

  //////////////////////////////
  // Unlock counter
  //////////////////////////////

  // Rise and fall see the same delay, so a low pulse adds its length
  // Wraps only after 2^32 unlocked cycles
  always_ff @(posedge adc_clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      unlock_cnt_o <= '0;
    end else if (!locked_s) begin
      unlock_cnt_o <= unlock_cnt_o + 1'b1;  // One per unlocked cycle
    end
  end

endmodule

// ==== src/dac_backend.sv ====
//////////////////////////////
// DAC output stage
// Generator plus controller sum with saturation
// Loopback samples, registered offset codes
//////////////////////////////

`include "rp_macros.svh"

module dac_backend (
  input  logic              adc_clk,
  input  logic              arst_n_i,
  // Generator contribution
  input  rp_pkg::sample_t   gen_a_i,
  input  rp_pkg::sample_t   gen_b_i,
  // Controller contribution
  input  rp_pkg::sample_t   ctl_a_i,
  input  rp_pkg::sample_t   ctl_b_i,
  // Saturated samples, combinational, for digital loopback
  output rp_pkg::sample_t   loop_a_o,
  output rp_pkg::sample_t   loop_b_o,
  // Codes to the converter
  output rp_pkg::dac_code_t dac_a_o,
  output rp_pkg::dac_code_t dac_b_o
);

  //////////////////////////////
  // Helpers
  //////////////////////////////

  // Clamp the guarded sum back into sample range
  function automatic rp_pkg::sample_t sat_sum(input rp_pkg::sum_t sum);
    logic ovf;
    logic sgn;
    ovf = sum[`RP_SMP_W] ^ sum[`RP_SMP_W-1];  // Guard and MSB disagree
    sgn = sum[`RP_SMP_W];
    if (ovf) begin
      sat_sum = {sgn, {(`RP_SMP_W-1){~sgn}}};  // +8191 or -8192
    end else begin
      sat_sum = sum[`RP_SMP_W-1:0];
    end
  endfunction

  // Two's complement to negative slope offset code
  function automatic rp_pkg::dac_code_t to_code(input rp_pkg::sample_t smp);
    to_code = {smp[`RP_SMP_W-1], ~smp[`RP_SMP_W-2:0]};
  endfunction

  rp_pkg::sum_t    sum_a;  // Guarded sums
  rp_pkg::sum_t    sum_b;

  rp_pkg::sample_t sat_a;  // Clamped
  rp_pkg::sample_t sat_b;

  //////////////////////////////
  // Sum and saturate
  //////////////////////////////

  // Signed operands, sign extended into the guard bit
  assign sum_a = gen_a_i + ctl_a_i;
  assign sum_b = gen_b_i + ctl_b_i;

  assign sat_a = sat_sum(sum_a);
  assign sat_b = sat_sum(sum_b);

  assign loop_a_o = sat_a;  // Same value the DAC sees
  assign loop_b_o = sat_b;

  //////////////////////////////
  // Code register
  //////////////////////////////

  // One code per channel, no interleave on the pins
  always_ff @(posedge adc_clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      dac_a_o <= {1'b0, {(`RP_SMP_W-1){1'b1}}};  // Code of a zero sample
      dac_b_o <= {1'b0, {(`RP_SMP_W-1){1'b1}}};
    end else begin
      dac_a_o <= to_code(sat_a);
      dac_b_o <= to_code(sat_b);
    end
  end

endmodule

// ==== src/adc_frontend.sv ====
//////////////////////////////
// ADC input stage
// Bit trim, negative slope to two's complement
// Digital loopback select, sample register
//////////////////////////////

`include "rp_macros.svh"

module adc_frontend (
  input  logic             adc_clk,
  input  logic             arst_n_i,
  // Raw converter words
  input  rp_pkg::adc_raw_t adc_a_i,
  input  rp_pkg::adc_raw_t adc_b_i,
  // Loopback from the DAC path
  input  logic             digital_loop_i,
  input  rp_pkg::sample_t  loop_a_i,
  input  rp_pkg::sample_t  loop_b_i,
  // Samples to the processing cores
  output rp_pkg::sample_t  adc_dat_a_o,
  output rp_pkg::sample_t  adc_dat_b_o
);

  // Upper bits of the raw word, LSBs are below the converter noise floor
  logic [`RP_SMP_W-1:0] trim_a;
  logic [`RP_SMP_W-1:0] trim_b;

  rp_pkg::sample_t      conv_a;  // After slope conversion
  rp_pkg::sample_t      conv_b;

  rp_pkg::sample_t      next_a;  // After loopback mux
  rp_pkg::sample_t      next_b;

  //////////////////////////////
  // Trim and convert
  //////////////////////////////

  assign trim_a = adc_a_i[`RP_ADC_IN_W-1 -: `RP_SMP_W];
  assign trim_b = adc_b_i[`RP_ADC_IN_W-1 -: `RP_SMP_W];

  // Keep MSB, flip the magnitude bits
  assign conv_a = {trim_a[`RP_SMP_W-1], ~trim_a[`RP_SMP_W-2:0]};
  assign conv_b = {trim_b[`RP_SMP_W-1], ~trim_b[`RP_SMP_W-2:0]};

  // Loopback replaces both channels at once
  assign next_a = digital_loop_i ? loop_a_i : conv_a;
  assign next_b = digital_loop_i ? loop_b_i : conv_b;

  //////////////////////////////
  // Sample register
  //////////////////////////////

  always_ff @(posedge adc_clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      adc_dat_a_o <= '0;  // Zero sample
      adc_dat_b_o <= '0;
    end else begin
      adc_dat_a_o <= next_a;
      adc_dat_b_o <= next_b;
    end
  end

endmodule

// ==== src/rp_pkg.sv ====
//////////////////////////////
// Shared types for the analog path
// Samples, DAC codes, expansion and daisy vectors
//////////////////////////////

`include "rp_macros.svh"

package rp_pkg;

  // Converter side
  typedef logic        [`RP_ADC_IN_W-1:0] adc_raw_t;   // Straight from the ADC pins
  typedef logic signed [`RP_SMP_W-1:0]    sample_t;    // Two's complement
  typedef logic signed [`RP_SMP_W:0]      sum_t;       // One guard bit for the adder
  typedef logic        [`RP_SMP_W-1:0]    dac_code_t;  // Negative slope offset code

  //////////////////////////////
  // Glue logic vectors
  //////////////////////////////

  typedef logic [`RP_EXP_W-1:0]   exp_vec_t;    // One expansion side
  typedef logic [`RP_PAR_W-1:0]   par_word_t;   // Daisy receive word

  // Bit 0 sync mode
  // Bit 1 trigger out on N0
  // Bit 2 selects generator trigger over scope trigger
  typedef logic [`RP_DMODE_W-1:0] daisy_mode_t;

  typedef logic [`RP_DIAG_W-1:0]  diag_cnt_t;   // Unlocked cycle count

endpackage

// ==== src/rp_macros.svh ====
//////////////////////////////
// Board-fixed widths for the ADC clock domain
// Sample, expansion, daisy and diagnostic sizes
// Lock synchronizer depth
//////////////////////////////

`ifndef RP_MACROS_SVH
`define RP_MACROS_SVH

// ADC side
`define RP_ADC_IN_W     16  // Raw converter word, two LSBs unused
`define RP_SMP_W        14  // Sample and DAC code width

// Expansion connector
`define RP_EXP_W        8   // Pins per side, P or N

// Daisy chain
`define RP_PAR_W        16  // Parallel word from the receiver
`define RP_DMODE_W      3   // Sync, trig out enable, gen trig select

// Diagnostics
`define RP_DIAG_W       32  // Unlock cycle counter
`define RP_SYNC_STAGES  2   // Flops on the async lock status

`endif
